/* src/cart_pkg.sv */
`default_nettype none

package cart_pkg;

   //////////////////////////////
   // Slot sequence

   localparam int SLOT_W = 4;  // Slot index width

   // Slot index counts down from SLOT_FIRST to 0, then parks
   localparam logic [SLOT_W-1:0] SLOT_IDLE      = 4'd12;
   localparam logic [SLOT_W-1:0] SLOT_FIRST     = 4'd11;
   localparam logic [SLOT_W-1:0] HOST_LAST_SLOT = 4'd5;   // Slots 5..0 belong to host

   // Latch slots inside the sequence
   localparam logic [SLOT_W-1:0] SNES_CAP_SLOT  = 4'd8;   // SRAM data to console latch
   localparam logic [SLOT_W-1:0] SNES_WR_SLOT   = 4'd9;   // Console data to write reg
   localparam logic [SLOT_W-1:0] HOST_WR_SLOT   = 4'd4;   // Host data to write reg
   localparam logic [SLOT_W-1:0] HOST_CAP_SLOT  = 4'd0;   // SRAM data to host latch

   //////////////////////////////
   // Address widths and regions

   localparam int SNES_AW = 24;  // Console CPU address
   localparam int MEM_AW  = 21;  // SRAM byte address, 2 MiB
   localparam int SRAM_AW = 20;  // SRAM word address

   // Save RAM sits in the top 64 KiB of the SRAM
   localparam logic [MEM_AW-1:0] SAVERAM_BASE = 21'h1F0000;

   // Console address seen through either mapper
   typedef union packed {
      struct packed {
         logic [7:0]  bank;
         logic        a15;     // Upper half of a 64 KiB bank
         logic [14:0] offset;  // 32 KiB window
      } lo;
      struct packed {
         logic [7:0]  bank;
         logic [15:0] offset;  // Full 64 KiB bank
      } hi;
   } snes_addr_u;

endpackage

`default_nettype wire

/* src/slot_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module slot_counter (
   input  wire                         CLK2,
   input  wire                         rst_n,
   input  wire                         snes_rd_n,
   input  wire                         snes_wr_n,
   output logic                        cycle_start,
   output logic [cart_pkg::SLOT_W-1:0] slot_idx,
   output logic                        rd_s,
   output logic                        wr_s
);
   import cart_pkg::*;

   logic [1:0] rd_sync;  // Two flops on /RD
   logic [1:0] wr_sync;  // Two flops on /WR
   logic [2:0] rw_hist;  // Combined strobe history, newest in bit 0

   //////////////////////////////
   // Strobe synchronizers

   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         rd_sync <= 2'b11;  // Bus strobes idle high
         wr_sync <= 2'b11;
         rw_hist <= 3'b111;  // No false start out of reset
      end else begin
         rd_sync <= {rd_sync[0], snes_rd_n};
         wr_sync <= {wr_sync[0], snes_wr_n};
         rw_hist <= {rw_hist[1:0], rd_s & wr_s};
      end
   end

   assign rd_s = rd_sync[1];
   assign wr_s = wr_sync[1];

   // Combined strobe went high, high, low
   assign cycle_start = (rw_hist == 3'b110);

   //////////////////////////////
   // Slot index

   // Counts 11 down to 0, then parks at idle until the next start
   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         slot_idx <= SLOT_IDLE;
      end else if (cycle_start) begin
         slot_idx <= SLOT_FIRST;  // Also restarts a running sequence
      end else if (slot_idx == '0) begin
         slot_idx <= SLOT_IDLE;
      end else if (slot_idx != SLOT_IDLE) begin
         slot_idx <= slot_idx - 1'b1;
      end
   end

endmodule

`default_nettype wire

/* src/slot_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module slot_sequencer (
   input  wire                         CLK2,
   input  wire                         rst_n,
   input  wire                         cycle_start,
   input  wire [cart_pkg::SLOT_W-1:0]  slot_idx,
   input  wire                         rd_s,
   input  wire                         wr_s,
   input  wire                         is_saveram,
   input  wire                         host_rd,
   input  wire                         host_wr,
   output logic                        host_busy,
   output logic                        host_done,
   output logic                        host_phase,
   output logic                        sram_oe_n,
   output logic                        sram_we_n,
   output logic                        snes_to_mem,
   output logic                        mem_to_snes,
   output logic                        host_to_mem,
   output logic                        mem_to_host
);
   import cart_pkg::*;

   logic snes_rd_cyc;  // Console read latched at cycle start
   logic snes_wr_cyc;  // Console write latched at cycle start
   logic req_pend;     // Host request waiting for a cycle start
   logic req_armed;    // Host request owns this cycle's host phase
   logic host_is_wr;   // Direction of the held host request
   logic host_req;
   logic con_phase;    // Slots 11..6
   logic host_slot;    // Host phase with a request armed

   assign host_req = host_rd | host_wr;

   //////////////////////////////
   // Console cycle type

   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         snes_rd_cyc <= 1'b0;  // No access
         snes_wr_cyc <= 1'b0;
      end else if (cycle_start) begin
         snes_wr_cyc <= !wr_s;
         snes_rd_cyc <= !rd_s && wr_s;  // Write wins if both strobes low
      end
   end

   //////////////////////////////
   // Host request FSM

   // Idle, pending (both flags low / req_pend) or armed (req_armed)
   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         req_pend   <= 1'b0;
         req_armed  <= 1'b0;
         host_is_wr <= 1'b0;
         host_done  <= 1'b0;
      end else begin
         host_done <= 1'b0;
         if (req_armed && slot_idx == '0) begin
            // Last host slot done, read data lands with host_done
            req_armed <= 1'b0;
            host_done <= 1'b1;
         end else if (req_pend && cycle_start) begin
            req_pend  <= 1'b0;
            req_armed <= 1'b1;  // Served in this cycle's host phase
         end else if (host_req && !host_busy) begin
            req_pend   <= 1'b1;
            host_is_wr <= host_wr;  // Write wins on a double pulse
         end
      end
   end

   // Pulses while busy fall through the last branch above
   assign host_busy = req_pend | req_armed;

   //////////////////////////////
   // Slot decode

   assign host_phase = (slot_idx <= HOST_LAST_SLOT);
   assign con_phase  = (slot_idx > HOST_LAST_SLOT) && (slot_idx <= SLOT_FIRST);
   assign host_slot  = host_phase & req_armed;

   // Console writes reach the SRAM only inside save RAM
   assign sram_oe_n = !((con_phase & snes_rd_cyc) | (host_slot & !host_is_wr));
   assign sram_we_n = !((con_phase & snes_wr_cyc & is_saveram) | (host_slot & host_is_wr));

   // One-clock latch strobes for the data path
   assign snes_to_mem = snes_wr_cyc & (slot_idx == SNES_WR_SLOT);
   assign mem_to_snes = snes_rd_cyc & (slot_idx == SNES_CAP_SLOT);
   assign host_to_mem = req_armed & host_is_wr & (slot_idx == HOST_WR_SLOT);
   assign mem_to_host = req_armed & !host_is_wr & (slot_idx == HOST_CAP_SLOT);

endmodule

`default_nettype wire

/* src/addr_map.sv */
`timescale 1ns/100ps
`default_nettype none

module addr_map (
   input  wire                          CLK2,
   input  wire                          rst_n,
   input  wire [cart_pkg::SNES_AW-1:0]  snes_addr,
   input  wire                          mapper_hirom,
   input  wire [cart_pkg::MEM_AW-1:0]   rom_mask,
   input  wire [cart_pkg::MEM_AW-1:0]   saveram_mask,
   input  wire [cart_pkg::MEM_AW-1:0]   host_addr,
   input  wire                          host_addr_load,
   input  wire                          host_done,
   input  wire                          host_phase,
   output logic                         is_rom,
   output logic                         is_saveram,
   output logic [cart_pkg::SRAM_AW-1:0] sram_addr,
   output logic                         mem_a0
);
   import cart_pkg::*;

   snes_addr_u        a;              // Console address, both views
   logic              lo_rom;
   logic              lo_sav;
   logic              hi_rom;
   logic              hi_sav;
   logic [MEM_AW:0]   lo_rom_wide;    // Bank bit 6 drops off above 2 MiB
   logic [MEM_AW-1:0] rom_addr;
   logic [MEM_AW-1:0] sav_offs;       // Offset inside save RAM before masking
   logic [MEM_AW-1:0] sav_addr;
   logic [MEM_AW-1:0] snes_mem_addr;
   logic [MEM_AW-1:0] host_addr_q;    // Auto-incrementing host pointer
   logic [MEM_AW-1:0] sel_addr;

   assign a = snes_addr;  // Straight from the pins

   //////////////////////////////
   // Region decode

   assign lo_rom = a.lo.a15;
   assign lo_sav = !a.lo.a15 && (a.lo.bank >= 8'h70) && (a.lo.bank <= 8'h7D);
   assign hi_rom = a.hi.bank[6];
   assign hi_sav = (a.hi.bank[6:5] == 2'b01) && (a.hi.offset[15:13] == 3'b011);  // 6000-7FFF

   // Save RAM takes priority over ROM
   assign is_saveram = mapper_hirom ? hi_sav : lo_sav;
   assign is_rom     = !is_saveram && (mapper_hirom ? hi_rom : lo_rom);

   //////////////////////////////
   // Byte address per mapper

   assign lo_rom_wide = {a.lo.bank[6:0], a.lo.offset};
   assign rom_addr    = mapper_hirom ? ({a.hi.bank[4:0], a.hi.offset} & rom_mask)
                                     : (lo_rom_wide[MEM_AW-1:0] & rom_mask);

   assign sav_offs = mapper_hirom ? {4'b0, a.hi.bank[3:0], a.hi.offset[12:0]}
                                  : {2'b0, a.lo.bank[3:0], a.lo.offset};
   assign sav_addr = SAVERAM_BASE + (sav_offs & saveram_mask);

   assign snes_mem_addr = is_saveram ? sav_addr : rom_addr;

   //////////////////////////////
   // Host address pointer

   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         host_addr_q <= '0;
      end else if (host_addr_load) begin
         host_addr_q <= host_addr;
      end else if (host_done) begin
         host_addr_q <= host_addr_q + 1'b1;  // Next byte after each access
      end
   end

   // Host owns the SRAM address in slots 5..0
   assign sel_addr  = host_phase ? host_addr_q : snes_mem_addr;
   assign sram_addr = sel_addr[MEM_AW-1:1];  // Word address
   assign mem_a0    = sel_addr[0];           // Byte lane select

endmodule

`default_nettype wire

/* src/data_path.sv */
`timescale 1ns/100ps
`default_nettype none

module data_path (
   input  wire         CLK2,
   input  wire         rst_n,
   input  wire  [7:0]  snes_data_in,
   input  wire         snes_rd_n,
   input  wire         snes_cs_n,
   input  wire         is_rom,
   input  wire         is_saveram,
   input  wire  [7:0]  host_wdata,
   input  wire  [15:0] sram_rdata,
   input  wire         mem_a0,
   input  wire         sram_we_n,
   input  wire         snes_to_mem,
   input  wire         mem_to_snes,
   input  wire         host_to_mem,
   input  wire         mem_to_host,
   output logic [7:0]  snes_data_out,
   output logic        snes_data_oe,
   output logic [7:0]  host_rdata,
   output logic [15:0] sram_wdata,
   output logic        sram_bhe_n,
   output logic        sram_ble_n
);

   logic [7:0] rd_byte;  // SRAM lane picked by address bit 0

   //////////////////////////////
   // Write register toward SRAM

   // Same byte on both lanes, byte enables pick the one written
   always_ff @(posedge CLK2) begin
      if (snes_to_mem) begin
         sram_wdata <= {2{snes_data_in}};
      end else if (host_to_mem) begin
         sram_wdata <= {2{host_wdata}};
      end
   end

   //////////////////////////////
   // Read registers from SRAM

   // Even bytes live on the upper lane
   assign rd_byte = mem_a0 ? sram_rdata[7:0] : sram_rdata[15:8];

   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         snes_data_out <= 8'h00;
         host_rdata    <= 8'h00;
      end else begin
         if (mem_to_snes) begin
            snes_data_out <= rd_byte;  // Held until the next console capture
         end
         if (mem_to_host) begin
            host_rdata <= rd_byte;     // Valid with host_done
         end
      end
   end

   //////////////////////////////
   // Byte enables and console drive

   // One lane on a write, both lanes on a read
   assign sram_bhe_n = !sram_we_n ? mem_a0  : 1'b0;
   assign sram_ble_n = !sram_we_n ? !mem_a0 : 1'b0;

   // Drive the console bus only for a mapped read
   assign snes_data_oe = !snes_cs_n && !snes_rd_n && (is_rom || is_saveram);

endmodule

`default_nettype wire

/* src/cart_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cart_top (
   input  wire                          CLK2,
   input  wire                          rst_n,
   // Console bus
   input  wire [cart_pkg::SNES_AW-1:0]  snes_addr,
   input  wire                          snes_rd_n,
   input  wire                          snes_wr_n,
   input  wire                          snes_cs_n,
   input  wire [7:0]                    snes_data_in,
   output wire [7:0]                    snes_data_out,
   output wire                          snes_data_oe,
   // Mapper setup from the host
   input  wire                          mapper_hirom,
   input  wire [cart_pkg::MEM_AW-1:0]   rom_mask,
   input  wire [cart_pkg::MEM_AW-1:0]   saveram_mask,
   // Host access strobes
   input  wire [cart_pkg::MEM_AW-1:0]   host_addr,
   input  wire                          host_addr_load,
   input  wire                          host_rd,
   input  wire                          host_wr,
   input  wire [7:0]                    host_wdata,
   output wire [7:0]                    host_rdata,
   output wire                          host_busy,
   output wire                          host_done,
   // SRAM
   output wire [cart_pkg::SRAM_AW-1:0]  sram_addr,
   input  wire [15:0]                   sram_rdata,
   output wire [15:0]                   sram_wdata,
   output wire                          sram_oe_n,
   output wire                          sram_we_n,
   output wire                          sram_bhe_n,
   output wire                          sram_ble_n
);
   import cart_pkg::*;

   logic              cycle_start;
   logic [SLOT_W-1:0] slot_idx;
   logic              rd_s;
   logic              wr_s;
   logic              is_rom;
   logic              is_saveram;
   logic              host_phase;   // Slots 5..0
   logic              mem_a0;
   logic              snes_to_mem;
   logic              mem_to_snes;
   logic              host_to_mem;
   logic              mem_to_host;

   //////////////////////////////
   // Cycle timing and control

   slot_counter u_slot_counter (
      .CLK2        (CLK2),
      .rst_n       (rst_n),
      .snes_rd_n   (snes_rd_n),
      .snes_wr_n   (snes_wr_n),
      .cycle_start (cycle_start),
      .slot_idx    (slot_idx),
      .rd_s        (rd_s),
      .wr_s        (wr_s)
   );

   slot_sequencer u_slot_sequencer (
      .CLK2        (CLK2),
      .rst_n       (rst_n),
      .cycle_start (cycle_start),
      .slot_idx    (slot_idx),
      .rd_s        (rd_s),
      .wr_s        (wr_s),
      .is_saveram  (is_saveram),
      .host_rd     (host_rd),
      .host_wr     (host_wr),
      .host_busy   (host_busy),
      .host_done   (host_done),
      .host_phase  (host_phase),
      .sram_oe_n   (sram_oe_n),
      .sram_we_n   (sram_we_n),
      .snes_to_mem (snes_to_mem),
      .mem_to_snes (mem_to_snes),
      .host_to_mem (host_to_mem),
      .mem_to_host (mem_to_host)
   );

   //////////////////////////////
   // Address and data

   addr_map u_addr_map (
      .CLK2           (CLK2),
      .rst_n          (rst_n),
      .snes_addr      (snes_addr),
      .mapper_hirom   (mapper_hirom),
      .rom_mask       (rom_mask),
      .saveram_mask   (saveram_mask),
      .host_addr      (host_addr),
      .host_addr_load (host_addr_load),
      .host_done      (host_done),
      .host_phase     (host_phase),
      .is_rom         (is_rom),
      .is_saveram     (is_saveram),
      .sram_addr      (sram_addr),
      .mem_a0         (mem_a0)
   );

   data_path u_data_path (
      .CLK2          (CLK2),
      .rst_n         (rst_n),
      .snes_data_in  (snes_data_in),
      .snes_rd_n     (snes_rd_n),
      .snes_cs_n     (snes_cs_n),
      .is_rom        (is_rom),
      .is_saveram    (is_saveram),
      .host_wdata    (host_wdata),
      .sram_rdata    (sram_rdata),
      .mem_a0        (mem_a0),
      .sram_we_n     (sram_we_n),   // Byte enables follow the write strobe
      .snes_to_mem   (snes_to_mem),
      .mem_to_snes   (mem_to_snes),
      .host_to_mem   (host_to_mem),
      .mem_to_host   (mem_to_host),
      .snes_data_out (snes_data_out),
      .snes_data_oe  (snes_data_oe),
      .host_rdata    (host_rdata),
      .sram_wdata    (sram_wdata),
      .sram_bhe_n    (sram_bhe_n),
      .sram_ble_n    (sram_ble_n)
   );

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
   output logic CLK2
);

   initial begin
      CLK2 = 1'b0;
   end

   // 100 ns period
   always #50 CLK2 = ~CLK2;

endmodule

`default_nettype wire

/* verif/sram_model.sv */
`timescale 1ns/100ps
`default_nettype none

module sram_model (
   input  wire         CLK2,
   input  wire  [19:0] sram_addr,
   input  wire  [15:0] sram_wdata,
   output logic [15:0] sram_rdata,
   input  wire         sram_oe_n,
   input  wire         sram_we_n,
   input  wire         sram_bhe_n,
   input  wire         sram_ble_n
);

   logic [15:0] mem [0:(1<<20)-1];  // 1M words, 2 MiB

   // Power-up content from the full byte address
   function automatic logic [7:0] fill_byte(input logic [20:0] b);
      return b[7:0] ^ b[15:8] ^ {3'b101, b[20:16]};
   endfunction

   // Even byte on the upper lane
   initial begin
      for (int i = 0; i < (1 << 20); i++) begin
         mem[i] = {fill_byte({i[19:0], 1'b0}), fill_byte({i[19:0], 1'b1})};
      end
   end

   // Bus floats high, and so does a lane whose byte enable is off
   assign sram_rdata = sram_oe_n ? 16'hFFFF
                                 : (mem[sram_addr] | {{8{sram_bhe_n}}, {8{sram_ble_n}}});

   // Last clock of a low write strobe leaves the final data
   always @(posedge CLK2) begin
      if (!sram_we_n) begin
         if (!sram_bhe_n) begin
            mem[sram_addr][15:8] <= sram_wdata[15:8];
         end
         if (!sram_ble_n) begin
            mem[sram_addr][7:0] <= sram_wdata[7:0];
         end
      end
   end

endmodule

`default_nettype wire

/* verif/cart_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module cart_sva (
   input wire                        CLK2,
   input wire                        rst_n,
   input wire                        cycle_start,
   input wire [cart_pkg::SLOT_W-1:0] slot_idx,
   input wire                        is_saveram,
   input wire                        host_done,
   input wire                        sram_oe_n,
   input wire                        sram_we_n
);
   import cart_pkg::*;

   int   fail_cnt = 0;  // Failed assertions so far
   logic started;       // First cycle start seen
   logic con_slot;      // Slots 11..6

   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         started <= 1'b0;
      end else if (cycle_start) begin
         started <= 1'b1;
      end
   end

   assign con_slot = (slot_idx > HOST_LAST_SLOT) && (slot_idx <= SLOT_FIRST);

   //////////////////////////////
   // SRAM strobes

   a_strobe_excl: assert property (@(posedge CLK2) disable iff (!rst_n)
      !(!sram_oe_n && !sram_we_n))
      else begin
         $error("SRAM output enable and write enable both low");
         fail_cnt++;
      end

   a_we_saveram: assert property (@(posedge CLK2) disable iff (!rst_n)
      (!sram_we_n && con_slot) |-> is_saveram)
      else begin
         $error("Console phase write outside save RAM");
         fail_cnt++;
      end

   a_quiet_reset: assert property (@(posedge CLK2) disable iff (!rst_n)
      !started |-> (sram_oe_n && sram_we_n))
      else begin
         $error("SRAM strobe active before the first cycle start");
         fail_cnt++;
      end

   //////////////////////////////
   // Host completion

   a_done_pulse: assert property (@(posedge CLK2) disable iff (!rst_n)
      host_done |=> !host_done)
      else begin
         $error("host_done held longer than one clock");
         fail_cnt++;
      end

endmodule

bind slot_sequencer cart_sva u_cart_sva (
   .CLK2        (CLK2),
   .rst_n       (rst_n),
   .cycle_start (cycle_start),
   .slot_idx    (slot_idx),
   .is_saveram  (is_saveram),
   .host_done   (host_done),
   .sram_oe_n   (sram_oe_n),
   .sram_we_n   (sram_we_n)
);

`default_nettype wire

/* verif/tb_cart.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cart;
   import cart_pkg::*;

   wire         CLK2;
   logic        rst_n;
   logic [23:0] snes_addr;
   logic        snes_rd_n;
   logic        snes_wr_n;
   logic        snes_cs_n;
   logic [7:0]  snes_data_in;
   logic        mapper_hirom;
   logic [20:0] rom_mask;
   logic [20:0] saveram_mask;
   logic [20:0] host_addr;
   logic        host_addr_load;
   logic        host_rd;
   logic        host_wr;
   logic [7:0]  host_wdata;
   wire  [7:0]  snes_data_out;
   wire         snes_data_oe;
   wire  [7:0]  host_rdata;
   wire         host_busy;
   wire         host_done;
   wire  [19:0] sram_addr;
   wire  [15:0] sram_rdata;
   wire  [15:0] sram_wdata;
   wire         sram_oe_n;
   wire         sram_we_n;
   wire         sram_bhe_n;
   wire         sram_ble_n;

   int          errors;
   int          done_cnt;       // host_done pulses in the current access
   logic [7:0]  done_rdata;     // host_rdata seen with host_done
   bit          host_out;       // Host access outstanding
   logic [20:0] host_ptr;       // Expected host pointer
   logic [7:0]  ref_mem [logic [20:0]];  // Bytes written so far

   tb_clkgen u_clkgen (.CLK2(CLK2));

   cart_top u_dut (.*);

   sram_model u_sram (
      .CLK2       (CLK2),
      .sram_addr  (sram_addr),
      .sram_wdata (sram_wdata),
      .sram_rdata (sram_rdata),
      .sram_oe_n  (sram_oe_n),
      .sram_we_n  (sram_we_n),
      .sram_bhe_n (sram_bhe_n),
      .sram_ble_n (sram_ble_n)
   );

   //////////////////////////////
   // Reference model

   function automatic logic [7:0] fill_byte(input logic [20:0] b);
      return b[7:0] ^ b[15:8] ^ {3'b101, b[20:16]};  // Same power-up fill as the SRAM
   endfunction

   function automatic logic [7:0] ref_byte(input logic [20:0] b);
      return ref_mem.exists(b) ? ref_mem[b] : fill_byte(b);
   endfunction

   // Mapper rules, save RAM first
   function automatic void map_addr(input logic [23:0] addr, input bit hirom,
                                    output bit rom, output bit sav, output logic [20:0] ma);
      snes_addr_u u;
      u = addr;
      if (hirom) begin
         sav = (u.hi.bank[6:5] == 2'b01) && (u.hi.offset >= 16'h6000)
               && (u.hi.offset <= 16'h7FFF);
         rom = !sav && u.hi.bank[6];
         if (sav) begin
            ma = SAVERAM_BASE + ({4'h0, u.hi.bank[3:0], u.hi.offset[12:0]} & saveram_mask);
         end else begin
            ma = {u.hi.bank[4:0], u.hi.offset} & rom_mask;
         end
      end else begin
         sav = !u.lo.a15 && (u.lo.bank >= 8'h70) && (u.lo.bank <= 8'h7D);
         rom = !sav && u.lo.a15;
         if (sav) begin
            ma = SAVERAM_BASE + ({2'b00, u.lo.bank[3:0], u.lo.offset} & saveram_mask);
         end else begin
            ma = {u.lo.bank[5:0], u.lo.offset} & rom_mask;  // Bank bit 6 lies past 2 MiB
         end
      end
   endfunction

   //////////////////////////////
   // Checks

   function automatic void check_byte(input string name, input logic [7:0] got,
                                      input logic [7:0] exp);
      assert (got == exp) else begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endfunction

   function automatic void check_bit(input string name, input logic got, input logic exp);
      assert (got == exp) else begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endfunction

   // Runs on every sampling edge
   function automatic void sample_host();
      if (host_done) begin
         done_cnt++;
         done_rdata = host_rdata;
         host_out   = 1'b0;
      end else if (host_out) begin
         check_bit("host_busy", host_busy, 1'b1);  // Busy until done
      end
   endfunction

   task automatic tick();
      @(negedge CLK2);
      sample_host();
   endtask

   //////////////////////////////
   // Bus tasks

   // One console cycle, strobe low until the capture is sampled
   task automatic bus_cycle(input logic [23:0] addr, input bit wr, input logic [7:0] wdata,
                            input bit cs_n, output logic [7:0] rdata);
      int          k;
      bit          rom;
      bit          sav;
      logic [20:0] ma;
      bit          exp_oe;
      map_addr(addr, mapper_hirom, rom, sav, ma);
      exp_oe       = !cs_n && !wr && (rom || sav);
      snes_addr    = addr;
      snes_data_in = wdata;
      snes_cs_n    = cs_n;
      snes_rd_n    = wr;
      snes_wr_n    = !wr;
      k = 0;
      while (!u_dut.cycle_start && k < 8) begin  // Synchronizer delay is 3 clocks
         tick();
         k++;
      end
      if (!u_dut.cycle_start) begin
         $display("Timeout: bus strobe fell but no cycle start followed");
         errors++;
      end
      for (k = 0; k < 6; k++) begin
         tick();
         if (wr && !sav) check_bit("sram_we_n", sram_we_n, 1'b1);  // ROM stays untouched
      end
      rdata = snes_data_out;  // Captured in slot 8
      check_bit("snes_data_oe", snes_data_oe, exp_oe);
      snes_rd_n = 1'b1;
      snes_wr_n = 1'b1;
      snes_cs_n = 1'b1;
      k = 0;
      while (u_dut.slot_idx != SLOT_IDLE && k < 16) begin
         tick();
         if (wr && !sav) check_bit("sram_we_n", sram_we_n, 1'b1);
         k++;
      end
      if (u_dut.slot_idx != SLOT_IDLE) begin
         $display("Timeout: slot sequence did not return to idle");
         errors++;
      end
   endtask

   task automatic console_read(input logic [23:0] addr);
      logic [7:0]  got;
      bit          rom;
      bit          sav;
      logic [20:0] ma;
      map_addr(addr, mapper_hirom, rom, sav, ma);
      bus_cycle(addr, 1'b0, 8'h00, 1'b0, got);
      check_byte("snes_data_out", got, ref_byte(ma));
   endtask

   task automatic console_write(input logic [23:0] addr, input logic [7:0] d);
      logic [7:0]  got;
      bit          rom;
      bit          sav;
      logic [20:0] ma;
      map_addr(addr, mapper_hirom, rom, sav, ma);
      bus_cycle(addr, 1'b1, d, 1'b0, got);
      if (sav) ref_mem[ma] = d;  // Only save RAM takes console writes
   endtask

   task automatic load_host_addr(input logic [20:0] a);
      host_addr      = a;
      host_addr_load = 1'b1;
      tick();
      host_addr_load = 1'b0;
      host_ptr       = a;
   endtask

   // Host byte access, served in the host phase of an idle console read
   task automatic host_access(input bit wr, input logic [7:0] wdata, input bit extra_pulse);
      logic [7:0] idle_rd;
      int         k;
      done_cnt   = 0;
      host_wr    = wr;
      host_rd    = !wr;
      host_wdata = wdata;
      host_out   = 1'b1;
      tick();
      host_wr = 1'b0;
      host_rd = 1'b0;
      if (extra_pulse) begin
         host_rd = wr;  // Opposite request while busy
         host_wr = !wr;
         tick();
         host_rd = 1'b0;
         host_wr = 1'b0;
      end
      bus_cycle(24'h000000, 1'b0, 8'h00, 1'b1, idle_rd);
      if (extra_pulse) bus_cycle(24'h000000, 1'b0, 8'h00, 1'b1, idle_rd);
      k = 0;
      while (done_cnt == 0 && k < 40) begin
         tick();
         k++;
      end
      if (done_cnt == 0) begin
         $display("Timeout: host access never signalled host_done");
         errors++;
      end else begin
         check_byte("host_done count", 8'(done_cnt), 8'h01);
      end
      if (wr) begin
         ref_mem[host_ptr] = wdata;
      end else begin
         check_byte("host_rdata", done_rdata, ref_byte(host_ptr));
      end
      host_ptr++;  // Pointer advances once per access
   endtask

   //////////////////////////////
   // Stimulus

   initial begin
      logic [31:0] r;
      logic [20:0] start;
      logic [23:0] a;
      logic [7:0]  d;
      void'($urandom(32'h1df9_090d));
      rst_n          = 1'b0;
      snes_addr      = '0;
      snes_rd_n      = 1'b1;
      snes_wr_n      = 1'b1;
      snes_cs_n      = 1'b1;
      snes_data_in   = '0;
      mapper_hirom   = 1'b0;
      rom_mask       = 21'h0F_FFFF;  // 1 MiB ROM
      saveram_mask   = 21'h00_7FFF;  // 32 KiB save RAM
      host_addr      = '0;
      host_addr_load = 1'b0;
      host_rd        = 1'b0;
      host_wr        = 1'b0;
      host_wdata     = '0;
      errors         = 0;
      done_cnt       = 0;
      done_rdata     = '0;
      host_out       = 1'b0;
      host_ptr       = '0;
      repeat (5) @(negedge CLK2);
      rst_n = 1'b1;
      tick();

      // Host writes then reads back 16 bytes
      r     = $urandom;
      start = r[20:0];
      load_host_addr(start);
      for (int i = 0; i < 16; i++) begin
         r = $urandom;
         host_access(1'b1, r[7:0], 1'b0);
      end
      load_host_addr(start);
      for (int i = 0; i < 16; i++) begin
         host_access(1'b0, 8'h00, 1'b0);
      end

      // ROM reads in both mappers
      for (int i = 0; i < 8; i++) begin
         r     = $urandom;
         a     = r[23:0];
         a[15] = 1'b1;  // LoROM upper half
         console_read(a);
      end
      mapper_hirom = 1'b1;
      for (int i = 0; i < 8; i++) begin
         r     = $urandom;
         a     = r[23:0];
         a[22] = 1'b1;  // HiROM bank bit 6
         console_read(a);
      end

      // Save RAM writes and read back
      mapper_hirom = 1'b0;
      for (int i = 0; i < 4; i++) begin
         r = $urandom;
         a = {8'h70 + 8'(r[31:24] % 8'd14), 1'b0, r[14:0]};
         d = r[22:15];
         console_write(a, d);
         console_read(a);
      end
      mapper_hirom = 1'b1;
      for (int i = 0; i < 4; i++) begin
         r = $urandom;
         a = {r[31], 2'b01, r[28:24], 3'b011, r[12:0]};  // Offset 6000..7FFF
         d = r[20:13];
         console_write(a, d);
         console_read(a);
      end

      // ROM write must be dropped
      mapper_hirom = 1'b0;
      r     = $urandom;
      a     = r[23:0];
      a[15] = 1'b1;
      console_write(a, ~r[31:24]);
      console_read(a);

      // Request while busy is ignored
      r     = $urandom;
      start = r[20:0];
      load_host_addr(start);
      host_access(1'b1, r[31:24], 1'b1);
      host_access(1'b0, 8'h00, 1'b0);  // Lands on start + 1
      load_host_addr(start);
      host_access(1'b0, 8'h00, 1'b0);

      $display("Errors: %0d in value and timeout checks, %0d in protocol assertions",
               errors, u_dut.u_slot_sequencer.u_cart_sva.fail_cnt);
      if (errors == 0 && u_dut.u_slot_sequencer.u_cart_sva.fail_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
src/cart_pkg.sv
src/slot_counter.sv
src/slot_sequencer.sv
src/addr_map.sv
src/data_path.sv
src/cart_top.sv
verif/tb_clkgen.sv
verif/sram_model.sv
verif/cart_sva.sv
verif/tb_cart.sv

/* Makefile */
TOP := tb_cart

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -Mdir obj_dir -f sim.f

# Pass only if the log holds the pass line
run: compile
	-./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1
	cat sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
